// ==== tb.f ====
+incdir+.
soc_pkg.sv
periph_ram.sv
byte_reg_file.sv
axil_req_capture.sv
addr_router.sv
axil_rsp_return.sv
periph_fabric_top.sv
tb_clock_gen.sv
tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build with Verilator, run the simulation, and fail when the log reports a failed regression
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps --top-module tb_top \
    -f tb.f > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vtb_top > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "Regression failed" sim.log && exit 1 || exit 0

// ==== tb_top.sv ====
// Testbench top driving the fabric's AXI-Lite host port and checking replies with assertions
`timescale 1ns/100ps
`default_nettype none

`include "soc_cfg.svh"

module tb_top;

    localparam int DRIVE_DLY = 2;
    // About 170 transactions of up to 14 cycles each plus reset
    localparam int CYCLE_LIMIT = 4000;
    localparam int RAM_SPAN = `SOC_RAM_WORDS_LOG2 + 2;
    localparam int BREG_SPAN = `SOC_BREG_COUNT_LOG2 + 2;
    localparam soc_pkg::addr_t RAM_BASE = `SOC_RAM_BASE;
    localparam soc_pkg::addr_t BREG_BASE = `SOC_BREG_BASE;

    logic clock;
    logic rst_n;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    soc_pkg::addr_t awaddr, araddr;
    soc_pkg::data_t wdata, rdata;
    soc_pkg::strb_t wstrb;
    soc_pkg::resp_t bresp, rresp;

    int errors = 0;
    int cycle_count;
    logic [31:0] lcg_state;
    string test_name = "reset";
    soc_pkg::resp_t exp_bresp, exp_rresp;
    soc_pkg::data_t exp_rdata;
    soc_pkg::data_t shadow_ram [2**`SOC_RAM_WORDS_LOG2];
    soc_pkg::byte_t shadow_breg [2**`SOC_BREG_COUNT_LOG2];
    logic pair_mode, pair_b_done;
    logic wr_accept, rd_accept, hs, hs_q, busy_q;

    tb_clock_gen u_clock_gen (.clock_o(clock), .rst_n_o(rst_n));

    periph_fabric_top dut_i (
        .clock_i   (clock),
        .rst_n_i   (rst_n),
        .awvalid_i (awvalid),
        .awaddr_i  (awaddr),
        .awready_o (awready),
        .wvalid_i  (wvalid),
        .wdata_i   (wdata),
        .wstrb_i   (wstrb),
        .wready_o  (wready),
        .bvalid_o  (bvalid),
        .bresp_o   (bresp),
        .bready_i  (bready),
        .arvalid_i (arvalid),
        .araddr_i  (araddr),
        .arready_o (arready),
        .rvalid_o  (rvalid),
        .rdata_o   (rdata),
        .rresp_o   (rresp),
        .rready_i  (rready)
    );

    assign wr_accept = awvalid && awready && wvalid && wready;
    assign rd_accept = arvalid && arready;
    assign hs = (bvalid && bready) || (rvalid && rready);

    function automatic void report_error(input string msg);
        errors++;
        $display("%s", msg);
    endfunction

    // Expected busy window from the accept edge to the edge after the response handshake
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            hs_q   <= 1'b0;
        end else begin
            hs_q <= hs;
            if (wr_accept || rd_accept) begin
                busy_q <= 1'b1;
            end else if (hs_q) begin
                busy_q <= 1'b0;
            end
        end
    end

    assert property (@(posedge clock)
        $rose(rst_n) |-> !bvalid && !rvalid && awready && wready && arready)
        else report_error("Reset state wrong, a valid is high or a ready is low");
    assert property (@(posedge clock) disable iff (!rst_n)
        busy_q |-> !awready && !wready && !arready)
        else report_error($sformatf("%s: a ready is high while a transaction is open",
                                    test_name));
    assert property (@(posedge clock) disable iff (!rst_n)
        !busy_q |-> awready && wready && (arready == !(awvalid && wvalid)))
        else report_error($sformatf("%s: idle readies wrong or read not held off by a write",
                                    test_name));
    // Valid changes on the third edge after accept and samples high on the fourth
    assert property (@(posedge clock) disable iff (!rst_n)
        $past(wr_accept, 4) == $rose(bvalid))
        else report_error($sformatf("%s: write response not exactly 3 edges after accept",
                                    test_name));
    assert property (@(posedge clock) disable iff (!rst_n)
        $past(rd_accept, 4) == $rose(rvalid))
        else report_error($sformatf("%s: read response not exactly 3 edges after accept",
                                    test_name));
    assert property (@(posedge clock) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else report_error($sformatf("%s: write response changed while the host stalled",
                                    test_name));
    assert property (@(posedge clock) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else report_error($sformatf("%s: read response changed while the host stalled",
                                    test_name));
    assert property (@(posedge clock) disable iff (!rst_n)
        bvalid && bready |-> bresp == exp_bresp)
        else report_error($sformatf("Mismatch %s: bresp expected %h, actual %h",
                                    test_name, exp_bresp, bresp));
    assert property (@(posedge clock) disable iff (!rst_n)
        rvalid && rready |-> rresp == exp_rresp)
        else report_error($sformatf("Mismatch %s: rresp expected %h, actual %h",
                                    test_name, exp_rresp, rresp));
    assert property (@(posedge clock) disable iff (!rst_n)
        rvalid && rready |-> rdata == exp_rdata)
        else report_error($sformatf("Mismatch %s: rdata expected %h, actual %h",
                                    test_name, exp_rdata, rdata));
    assert property (@(posedge clock) disable iff (!rst_n)
        $rose(rvalid) && pair_mode |-> pair_b_done)
        else report_error($sformatf("%s: read answered before the paired write",
                                    test_name));

    function automatic logic [31:0] rand_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int limit);
        logic [31:0] r;
        r = rand_word();
        return int'((r >> 16) % limit);
    endfunction

    function automatic logic in_ram(input soc_pkg::addr_t addr);
        return addr[31:RAM_SPAN] == RAM_BASE[31:RAM_SPAN];
    endfunction

    function automatic logic in_breg(input soc_pkg::addr_t addr);
        return addr[31:BREG_SPAN] == BREG_BASE[31:BREG_SPAN];
    endfunction

    function automatic soc_pkg::addr_t ram_addr(input int slot);
        return RAM_BASE | {20'd0, 10'((slot * 67) % 1024), 2'b00};
    endfunction

    function automatic soc_pkg::addr_t breg_addr(input int idx);
        return BREG_BASE | {28'd0, 2'(idx), 2'b00};
    endfunction

    // Addresses that hit neither window
    function automatic soc_pkg::addr_t bad_addr(input int idx);
        case (idx)
            0: return 32'h0000_0000;
            1: return 32'h8000_1000;
            2: return 32'h1000_0010;
            3: return 32'h7fff_fffc;
            default: return 32'hffff_fff0;
        endcase
    endfunction

    task automatic step();
        @(posedge clock);
        #(DRIVE_DLY);
    endtask

    task automatic drive_write(input string name, input soc_pkg::addr_t addr,
                               input soc_pkg::data_t data, input soc_pkg::strb_t strb);
        test_name = name;
        exp_bresp = (in_ram(addr) || in_breg(addr)) ? `SOC_RESP_OKAY : `SOC_RESP_DECERR;
        if (in_ram(addr)) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (strb[lane]) begin
                    shadow_ram[addr[RAM_SPAN-1:2]][lane*8 +: 8] = data[lane*8 +: 8];
                end
            end
        end else if (in_breg(addr) && strb[0]) begin
            shadow_breg[addr[BREG_SPAN-1:2]] = data[7:0];
        end
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        wstrb   = strb;
    endtask

    task automatic drive_read(input string name, input soc_pkg::addr_t addr);
        test_name = name;
        exp_rresp = `SOC_RESP_DECERR;
        exp_rdata = '0;
        if (in_ram(addr)) begin
            exp_rresp = `SOC_RESP_OKAY;
            exp_rdata = shadow_ram[addr[RAM_SPAN-1:2]];
        end else if (in_breg(addr)) begin
            exp_rresp = `SOC_RESP_OKAY;
            exp_rdata = {4{shadow_breg[addr[BREG_SPAN-1:2]]}};
        end
        arvalid = 1'b1;
        araddr  = addr;
    endtask

    // Holds ready low for stall cycles after valid shows and then takes the response
    task automatic take_response(input logic is_write, input int stall);
        do begin
            @(negedge clock);
        end while (is_write ? !bvalid : !rvalid);
        repeat (stall) step();
        bready = bready | is_write;
        rready = rready | !is_write;
        step();
        bready = 1'b0;
        rready = 1'b0;
    endtask

    task automatic write_txn(input string name, input soc_pkg::addr_t addr,
                             input soc_pkg::data_t data, input soc_pkg::strb_t strb);
        int stall;
        stall = rand_below(9);
        drive_write(name, addr, data, strb);
        bready = (stall == 0);
        do begin
            @(negedge clock);
        end while (!awready);
        step();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        take_response(1'b1, stall);
    endtask

    task automatic read_txn(input string name, input soc_pkg::addr_t addr);
        int stall;
        stall = rand_below(9);
        drive_read(name, addr);
        rready = (stall == 0);
        do begin
            @(negedge clock);
        end while (!arready);
        step();
        arvalid = 1'b0;
        take_response(1'b0, stall);
    endtask

    // Write and read offered together so the read sees the new data
    task automatic pair_txn(input string name, input soc_pkg::addr_t addr);
        pair_mode   = 1'b1;
        pair_b_done = 1'b0;
        drive_write(name, addr, rand_word(), soc_pkg::strb_t'(rand_word() >> 28));
        drive_read(name, addr);
        bready = 1'b1;
        rready = 1'b1;
        do begin
            @(negedge clock);
        end while (!awready);
        step();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        take_response(1'b1, 0);
        pair_b_done = 1'b1;
        rready = 1'b1;
        do begin
            @(negedge clock);
        end while (!arready);
        step();
        arvalid = 1'b0;
        take_response(1'b0, 0);
        pair_mode = 1'b0;
    endtask

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles, errors %0d", CYCLE_LIMIT, errors);
        $display("Regression failed");
        $finish;
    end

    initial begin : stimulus
        int slot;
        lcg_state = 32'h7eb7_3ffa;
        {awvalid, wvalid, arvalid, bready, rready} = '0;
        {awaddr, wdata, wstrb, araddr} = '0;
        {pair_mode, pair_b_done} = '0;
        {exp_bresp, exp_rresp, exp_rdata} = '0;
        for (int i = 0; i < 4; i++) begin
            shadow_breg[i] = '0;
        end
        wait (rst_n === 1'b1);
        step();

        for (int i = 0; i < 16; i++) begin
            write_txn("ram_fill", ram_addr(i), rand_word(), 4'hf);
        end
        repeat (80) begin
            slot = rand_below(16);
            if (rand_below(2) == 1) begin
                write_txn("ram_write", ram_addr(slot), rand_word(),
                          soc_pkg::strb_t'(rand_word() >> 28));
            end else begin
                read_txn("ram_read", ram_addr(slot));
            end
        end

        for (int i = 0; i < 4; i++) begin
            read_txn("breg_reset", breg_addr(i));
        end
        write_txn("breg_lane0", breg_addr(2), 32'h0000_00a5, 4'h1);
        write_txn("breg_no_lane0", breg_addr(2), 32'h5a5a_5a5a, 4'he);
        read_txn("breg_no_lane0", breg_addr(2));
        repeat (30) begin
            slot = rand_below(4);
            if (rand_below(2) == 1) begin
                write_txn("breg_write", breg_addr(slot), rand_word(),
                          soc_pkg::strb_t'(rand_word() >> 28));
            end else begin
                read_txn("breg_read", breg_addr(slot));
            end
        end

        for (int i = 0; i < 5; i++) begin
            write_txn("decerr_write", bad_addr(i), rand_word(), 4'hf);
            read_txn("decerr_read", bad_addr(i));
        end
        for (int i = 0; i < 16; i++) begin
            read_txn("ram_after_decerr", ram_addr(i));
        end
        for (int i = 0; i < 4; i++) begin
            read_txn("breg_after_decerr", breg_addr(i));
        end

        for (int i = 0; i < 3; i++) begin
            pair_txn("pair_ram", ram_addr(rand_below(16)));
        end
        pair_txn("pair_breg", breg_addr(1));
        pair_txn("pair_decerr", bad_addr(3));

        repeat (4) step();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
// Testbench clock and reset source: 40 ns clock, reset held low for the first 10 rising edges
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic clock_o,
    output logic rst_n_o
);

    initial begin
        clock_o = 1'b0;
        forever begin
            #20 clock_o = ~clock_o;
        end
    end

    // Release just after the tenth edge, like any other stimulus
    initial begin
        rst_n_o = 1'b0;
        repeat (10) @(posedge clock_o);
        #2 rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// ==== periph_fabric_top.sv ====
// Top of the data-bus peripheral fabric: AXI-Lite host port, address router and response return
`timescale 1ns/100ps
`default_nettype none

module periph_fabric_top (
    input  wire logic           clock_i,
    input  wire logic           rst_n_i,

    input  wire logic           awvalid_i,
    input  wire soc_pkg::addr_t awaddr_i,
    output logic                awready_o,

    input  wire logic           wvalid_i,
    input  wire soc_pkg::data_t wdata_i,
    input  wire soc_pkg::strb_t wstrb_i,
    output logic                wready_o,

    output logic                bvalid_o,
    output soc_pkg::resp_t      bresp_o,
    input  wire logic           bready_i,

    input  wire logic           arvalid_i,
    input  wire soc_pkg::addr_t araddr_i,
    output logic                arready_o,

    output logic                rvalid_o,
    output soc_pkg::data_t      rdata_o,
    output soc_pkg::resp_t      rresp_o,
    input  wire logic           rready_i
);

    logic          req_valid;
    soc_pkg::req_t req;
    logic          rsp_valid;
    soc_pkg::rsp_t rsp;
    logic          done;

    axil_req_capture u_capture (
        .clock_i     (clock_i),
        .rst_n_i     (rst_n_i),
        .awvalid_i   (awvalid_i),
        .awaddr_i    (awaddr_i),
        .awready_o   (awready_o),
        .wvalid_i    (wvalid_i),
        .wdata_i     (wdata_i),
        .wstrb_i     (wstrb_i),
        .wready_o    (wready_o),
        .arvalid_i   (arvalid_i),
        .araddr_i    (araddr_i),
        .arready_o   (arready_o),
        .done_i      (done),
        .req_valid_o (req_valid),
        .req_o       (req)
    );

    addr_router u_router (
        .clock_i     (clock_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid),
        .req_i       (req),
        .rsp_valid_o (rsp_valid),
        .rsp_o       (rsp)
    );

    axil_rsp_return u_return (
        .clock_i     (clock_i),
        .rst_n_i     (rst_n_i),
        .rsp_valid_i (rsp_valid),
        .rsp_i       (rsp),
        .bvalid_o    (bvalid_o),
        .bresp_o     (bresp_o),
        .bready_i    (bready_i),
        .rvalid_o    (rvalid_o),
        .rdata_o     (rdata_o),
        .rresp_o     (rresp_o),
        .rready_i    (rready_i),
        .done_o      (done)
    );

endmodule

`default_nettype wire

// ==== axil_rsp_return.sv ====
// Output side of the fabric: drives the reply on B or R and holds it until the host takes it
`timescale 1ns/100ps
`default_nettype none

module axil_rsp_return (
    input  wire logic          clock_i,
    input  wire logic          rst_n_i,
    input  wire logic          rsp_valid_i,
    input  wire soc_pkg::rsp_t rsp_i,

    output logic               bvalid_o,
    output soc_pkg::resp_t     bresp_o,
    input  wire logic          bready_i,

    output logic               rvalid_o,
    output soc_pkg::data_t     rdata_o,
    output soc_pkg::resp_t     rresp_o,
    input  wire logic          rready_i,

    output logic               done_o
);

    logic b_hs;
    logic r_hs;

    assign b_hs = bvalid_o && bready_i;
    assign r_hs = rvalid_o && rready_i;

    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            bvalid_o <= 1'b0;
            rvalid_o <= 1'b0;
            done_o   <= 1'b0;
        end else begin
            done_o <= b_hs || r_hs;
            if (rsp_valid_i && rsp_i.is_write) begin
                bvalid_o <= 1'b1;
            end else if (b_hs) begin
                bvalid_o <= 1'b0;
            end
            if (rsp_valid_i && !rsp_i.is_write) begin
                rvalid_o <= 1'b1;
            end else if (r_hs) begin
                rvalid_o <= 1'b0;
            end
        end
    end

    // Payload only moves on a new reply, so it stays put under back-pressure
    always_ff @(posedge clock_i) begin
        if (rsp_valid_i) begin
            if (rsp_i.is_write) begin
                bresp_o <= rsp_i.resp;
            end else begin
                rdata_o <= rsp_i.data;
                rresp_o <= rsp_i.resp;
            end
        end
    end

endmodule

`default_nettype wire

// ==== addr_router.sv ====
// Address decode for the fabric: strobes the hit slot, makes decode errors and merges the replies
`timescale 1ns/100ps
`default_nettype none

`include "soc_cfg.svh"

module addr_router (
    input  wire logic          clock_i,
    input  wire logic          rst_n_i,
    input  wire logic          req_valid_i,
    input  wire soc_pkg::req_t req_i,
    output logic               rsp_valid_o,
    output soc_pkg::rsp_t      rsp_o
);

    localparam int RAM_SPAN_LOG2  = `SOC_RAM_WORDS_LOG2 + $clog2(`SOC_STRB_W);
    localparam int BREG_SPAN_LOG2 = `SOC_BREG_COUNT_LOG2 + $clog2(`SOC_STRB_W);

    soc_pkg::target_t sel;
    soc_pkg::target_t sel_q;
    logic             is_write_q;
    logic             ram_en;
    logic             breg_en;
    soc_pkg::data_t   ram_rdata;
    soc_pkg::data_t   breg_rdata;

    // Window match on the bits above each window's span
    assign sel.ram  = (req_i.addr >> RAM_SPAN_LOG2)
                      == (soc_pkg::addr_t'(`SOC_RAM_BASE) >> RAM_SPAN_LOG2);
    assign sel.breg = (req_i.addr >> BREG_SPAN_LOG2)
                      == (soc_pkg::addr_t'(`SOC_BREG_BASE) >> BREG_SPAN_LOG2);
    assign sel.err  = !sel.ram && !sel.breg;

    assign ram_en  = req_valid_i && sel.ram;
    assign breg_en = req_valid_i && sel.breg;

    periph_ram #(
        .WORDS_LOG2 (`SOC_RAM_WORDS_LOG2)
    ) u_periph_ram (
        .clock_i (clock_i),
        .en_i    (ram_en),
        .req_i   (req_i),
        .rdata_o (ram_rdata)
    );

    byte_reg_file u_byte_reg_file (
        .clock_i (clock_i),
        .rst_n_i (rst_n_i),
        .en_i    (breg_en),
        .req_i   (req_i),
        .rdata_o (breg_rdata)
    );

    // Select follows the target's registered read by the same cycle
    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            sel_q       <= '0;
            is_write_q  <= 1'b0;
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= req_valid_i;
            if (req_valid_i) begin
                sel_q      <= sel;
                is_write_q <= req_i.is_write;
            end
        end
    end

    always_comb begin
        rsp_o.is_write = is_write_q;
        rsp_o.resp     = sel_q.err ? `SOC_RESP_DECERR : `SOC_RESP_OKAY;
        rsp_o.data     = '0;
        if (!is_write_q) begin
            if (sel_q.ram) begin
                rsp_o.data = ram_rdata;
            end else if (sel_q.breg) begin
                rsp_o.data = breg_rdata;
            end
        end
    end

endmodule

`default_nettype wire

// ==== axil_req_capture.sv ====
// Input side of the fabric: takes one AXI-Lite write (AW+W) or read (AR) and issues it as a request
`timescale 1ns/100ps
`default_nettype none

`include "soc_cfg.svh"

module axil_req_capture (
    input  wire logic           clock_i,
    input  wire logic           rst_n_i,

    input  wire logic           awvalid_i,
    input  wire soc_pkg::addr_t awaddr_i,
    output logic                awready_o,

    input  wire logic           wvalid_i,
    input  wire soc_pkg::data_t wdata_i,
    input  wire soc_pkg::strb_t wstrb_i,
    output logic                wready_o,

    input  wire logic           arvalid_i,
    input  wire soc_pkg::addr_t araddr_i,
    output logic                arready_o,

    input  wire logic           done_i,
    output logic                req_valid_o,
    output soc_pkg::req_t       req_o
);

    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } state_e;

    state_e state_q;
    logic   wr_ready;
    logic   rd_ready;
    logic   wr_take;
    logic   rd_take;
    logic   accepted_q;

    // AW and W share one ready; a pending write holds off AR
    assign wr_ready = (state_q == ST_IDLE);
    assign rd_ready = (state_q == ST_IDLE) && !(awvalid_i && wvalid_i);

    assign awready_o = wr_ready;
    assign wready_o  = wr_ready;
    assign arready_o = rd_ready;

    assign wr_take = wr_ready && awvalid_i && wvalid_i;
    assign rd_take = rd_ready && arvalid_i;

    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            state_q     <= ST_IDLE;
            accepted_q  <= 1'b0;
            req_valid_o <= 1'b0;
        end else begin
            accepted_q  <= wr_take || rd_take;
            // Request pulse trails the accepting edge by one cycle
            req_valid_o <= accepted_q;
            case (state_q)
                ST_IDLE: begin
                    if (wr_take || rd_take) begin
                        state_q <= ST_BUSY;
                    end
                end
                ST_BUSY: begin
                    if (done_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Payload held stable for the whole transaction
    always_ff @(posedge clock_i) begin
        if (wr_take) begin
            req_o.is_write <= 1'b1;
            req_o.addr     <= awaddr_i;
            req_o.data     <= wdata_i;
            req_o.strb     <= wstrb_i;
        end else if (rd_take) begin
            req_o.is_write <= 1'b0;
            req_o.addr     <= araddr_i;
            req_o.data     <= '0;
            req_o.strb     <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== byte_reg_file.sv ====
// Slot 1 byte registers: lane 0 stores, reads copy the byte into every lane like the UART port
`timescale 1ns/100ps
`default_nettype none

`include "soc_cfg.svh"

module byte_reg_file (
    input  wire logic          clock_i,
    input  wire logic          rst_n_i,
    input  wire logic          en_i,
    input  wire soc_pkg::req_t req_i,
    output soc_pkg::data_t     rdata_o
);

    localparam int OFFS_W = $clog2(`SOC_STRB_W);

    soc_pkg::byte_t                  regs [2**`SOC_BREG_COUNT_LOG2];
    logic [`SOC_BREG_COUNT_LOG2-1:0] reg_idx;

    assign reg_idx = req_i.addr[`SOC_BREG_COUNT_LOG2+OFFS_W-1:OFFS_W];

    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 2**`SOC_BREG_COUNT_LOG2; i++) begin
                regs[i] <= '0;
            end
        end else if (en_i && req_i.is_write && req_i.strb[0]) begin
            regs[reg_idx] <= req_i.data[7:0];
        end
    end

    // Same byte on all lanes
    always_ff @(posedge clock_i) begin
        if (en_i && !req_i.is_write) begin
            rdata_o <= {(`SOC_DATA_W/8){regs[reg_idx]}};
        end
    end

endmodule

`default_nettype wire

// ==== periph_ram.sv ====
// Slot 0 peripheral RAM: word array with byte-strobed writes and a registered read port
`timescale 1ns/100ps
`default_nettype none

`include "soc_cfg.svh"

module periph_ram #(
    parameter int WORDS_LOG2 = `SOC_RAM_WORDS_LOG2
) (
    input  wire logic          clock_i,
    input  wire logic          en_i,
    input  wire soc_pkg::req_t req_i,
    output soc_pkg::data_t     rdata_o
);

    localparam int OFFS_W = $clog2(`SOC_STRB_W);

    soc_pkg::data_t        mem [2**WORDS_LOG2];
    logic [WORDS_LOG2-1:0] word_idx;

    // Word index sits just above the byte offset
    assign word_idx = req_i.addr[WORDS_LOG2+OFFS_W-1:OFFS_W];

    always_ff @(posedge clock_i) begin
        if (en_i) begin
            if (req_i.is_write) begin
                for (int lane = 0; lane < `SOC_STRB_W; lane++) begin
                    if (req_i.strb[lane]) begin
                        mem[word_idx][lane*8 +: 8] <= req_i.data[lane*8 +: 8];
                    end
                end
            end else begin
                rdata_o <= mem[word_idx];
            end
        end
    end

endmodule

`default_nettype wire

// ==== soc_pkg.sv ====
// Shared bus types for the peripheral fabric, referenced by scoped name from every RTL module
`default_nettype none

`include "soc_cfg.svh"

package soc_pkg;

    typedef logic [`SOC_ADDR_W-1:0] addr_t;
    typedef logic [`SOC_DATA_W-1:0] data_t;
    typedef logic [`SOC_STRB_W-1:0] strb_t;
    typedef logic [1:0]             resp_t;
    typedef logic [7:0]             byte_t;

    // One captured host transaction
    typedef struct packed {
        logic  is_write;
        addr_t addr;
        data_t data;
        strb_t strb;
    } req_t;

    // Reply headed back to the B or R channel
    typedef struct packed {
        logic  is_write;
        resp_t resp;
        data_t data;
    } rsp_t;

    // One-hot slot select
    typedef struct packed {
        logic err;
        logic breg;
        logic ram;
    } target_t;

endpackage

`default_nettype wire

// ==== soc_cfg.svh ====
// Bus widths, address map and response codes for the peripheral fabric, included by package and RTL
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// Host bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32
`define SOC_STRB_W 4

// Slot 0, peripheral RAM window
`define SOC_RAM_BASE 32'h8000_0000
`define SOC_RAM_WORDS_LOG2 10

// Slot 1, byte-wide register window (UART register port stand-in)
`define SOC_BREG_BASE 32'h1000_0000
`define SOC_BREG_COUNT_LOG2 2

// AXI response codes
`define SOC_RESP_OKAY 2'b00
`define SOC_RESP_DECERR 2'b11

`endif
